//--- hdl/vx_macros.svh
// widths and constants of the vector execute stage, included by the package and every RTL file
`ifndef VX_MACROS_SVH
`define VX_MACROS_SVH

// lane word, also the address width
`define VX_WORD_W 32

// element lanes per beat
`define VX_NLANES 2

// element write offset inside a vector register
`define VX_OFFSET_W 5

// segment field count (nf)
`define VX_NF_W 3

// vector register index
`define VX_REG_W 5

// byte step between unit-stride elements
`define VX_UNIT_STRIDE 4

`endif

//--- hdl/vx_pkg.sv
// shared enums, decode/memory bundles and the lane word union, referenced as vx_pkg::name
`include "vx_macros.svh"

package vx_pkg;

  typedef enum logic [1:0] {
    SEW8  = 2'd0,
    SEW16 = 2'd1,
    SEW32 = 2'd2
  } sew_e;

  // operand source
  typedef enum logic [1:0] {
    SRC_V    = 2'd0,
    SRC_I    = 2'd1,
    SRC_X    = 2'd2,
    SRC_NONE = 2'd3
  } src_e;

  typedef enum logic [2:0] {
    FU_ALU         = 3'd0,
    FU_MASK        = 3'd1,
    FU_MOVE        = 3'd2,
    FU_MOVE_SCALAR = 3'd3,
    FU_LS          = 3'd4
  } fu_e;

  typedef enum logic [2:0] {
    ALU_ADD = 3'd0,
    ALU_AND = 3'd1,
    ALU_OR  = 3'd2,
    ALU_XOR = 3'd3,
    ALU_MM  = 3'd4
  } aluop_e;

  typedef enum logic [1:0] {
    MM_MIN  = 2'd0,
    MM_MINU = 2'd1,
    MM_MAX  = 2'd2,
    MM_MAXU = 2'd3
  } minmax_e;

  // set-before/including/only-first
  typedef enum logic [1:0] {
    MASK_SBF  = 2'd0,
    MASK_SIF  = 2'd1,
    MASK_SOF  = 2'd2,
    MASK_NONE = 2'd3
  } mask_op_e;

  typedef enum logic [1:0] {
    STRIDE_UNIT    = 2'd0,
    STRIDE_STRIDED = 2'd1,
    STRIDE_SEGMENT = 2'd2
  } stride_e;

  // lane word, whole or split into SEW-sized elements
  typedef union packed {
    logic [`VX_WORD_W-1:0] word;
    logic [1:0][15:0]      h16;
    logic [3:0][7:0]       b8;
  } lane_word_u;

  typedef struct packed {
    logic                     valid;
    logic                     load;
    logic                     store;
    logic                     ls_idx;
    fu_e                      fu;
    aluop_e                   aluop;
    minmax_e                  minmax;
    mask_op_e                 mask_op;
    src_e                     rs1_src;
    src_e                     rs2_src;
    sew_e                     sew;
    sew_e                     eew;
    stride_e                  stride;
    logic [`VX_NF_W-1:0]      nf;
    logic [`VX_REG_W-1:0]     vd;
    logic [`VX_OFFSET_W-1:0]  woffset0;
    logic [`VX_OFFSET_W-1:0]  woffset1;
    logic [`VX_NLANES-1:0]    wen;
    logic                     reduction_ena;
    logic [`VX_WORD_W-1:0]    vs1_lane0;
    logic [`VX_WORD_W-1:0]    vs1_lane1;
    logic [`VX_WORD_W-1:0]    vs2_lane0;
    logic [`VX_WORD_W-1:0]    vs2_lane1;
    logic [`VX_WORD_W-1:0]    storedata0;
    logic [`VX_WORD_W-1:0]    storedata1;
    logic [`VX_WORD_W-1:0]    imm;
    logic [`VX_WORD_W-1:0]    xs1;
    logic [`VX_WORD_W-1:0]    xs2;
    logic [`VX_WORD_W-1:0]    stride_val;
  } dec_ex_t;

  typedef struct packed {
    logic                     load;
    logic                     store;
    logic                     ls_idx;
    logic [`VX_NLANES-1:0]    wen;
    logic [`VX_OFFSET_W-1:0]  woffset0;
    logic [`VX_OFFSET_W-1:0]  woffset1;
    logic [`VX_REG_W-1:0]     vd;
    sew_e                     eew;
    logic [`VX_WORD_W-1:0]    result0;
    logic [`VX_WORD_W-1:0]    result1;
    logic [`VX_WORD_W-1:0]    storedata0;
    logic [`VX_WORD_W-1:0]    storedata1;
  } ex_mem_t;

endpackage

//--- hdl/vx_operand_select.sv
// operand mux for both lanes, driving vs1/vs2 from vector, immediate or scalar sources
`timescale 1ns/10ps
`include "vx_macros.svh"

module vx_operand_select (
  input  vx_pkg::dec_ex_t        dec,
  output logic [`VX_WORD_W-1:0]  vs1_0,
  output logic [`VX_WORD_W-1:0]  vs1_1,
  output logic [`VX_WORD_W-1:0]  vs2_0,
  output logic [`VX_WORD_W-1:0]  vs2_1
);

  // vs1 side, imm and scalar go to both lanes
  always_comb begin
    case (dec.rs1_src)
      vx_pkg::SRC_V: begin
        vs1_0 = dec.vs1_lane0;
        vs1_1 = dec.vs1_lane1;
      end
      vx_pkg::SRC_I: begin
        vs1_0 = dec.imm;
        vs1_1 = dec.imm;
      end
      vx_pkg::SRC_X: begin
        vs1_0 = dec.xs1;
        vs1_1 = dec.xs1;
      end
      default: begin
        vs1_0 = '0;
        vs1_1 = '0;
      end
    endcase
  end

  // vs2 side, scalar comes from xs2
  always_comb begin
    case (dec.rs2_src)
      vx_pkg::SRC_V: begin
        vs2_0 = dec.vs2_lane0;
        vs2_1 = dec.vs2_lane1;
      end
      vx_pkg::SRC_I: begin
        vs2_0 = dec.imm;
        vs2_1 = dec.imm;
      end
      vx_pkg::SRC_X: begin
        vs2_0 = dec.xs2;
        vs2_1 = dec.xs2;
      end
      default: begin
        vs2_0 = '0;
        vs2_1 = '0;
      end
    endcase
  end

endmodule

//--- hdl/vx_lane_alu.sv
// single-lane element ALU with the in-word mask-first ops; used per lane and for reductions
`timescale 1ns/10ps
`include "vx_macros.svh"

module vx_lane_alu (
  input  logic [`VX_WORD_W-1:0]  vs1,
  input  logic [`VX_WORD_W-1:0]  vs2,
  input  vx_pkg::aluop_e         aluop,
  input  vx_pkg::minmax_e        minmax,
  input  vx_pkg::mask_op_e       mask_op,
  input  vx_pkg::fu_e            fu,
  input  vx_pkg::sew_e           sew,
  output logic [`VX_WORD_W-1:0]  result
);

  vx_pkg::lane_word_u     a;
  vx_pkg::lane_word_u     b;
  logic                   slt;
  logic                   sltu;
  logic [`VX_WORD_W-1:0]  alu_res;
  logic [`VX_WORD_W-1:0]  low_bit;
  logic [`VX_WORD_W-1:0]  mask_res;

  assign a.word = vs2;
  assign b.word = vs1;

  // element sits in the low bits of the word
  always_comb begin
    case (sew)
      vx_pkg::SEW8:  slt = $signed(a.b8[0]) < $signed(b.b8[0]);
      vx_pkg::SEW16: slt = $signed(a.h16[0]) < $signed(b.h16[0]);
      default:       slt = $signed(a.word) < $signed(b.word);
    endcase
  end

  assign sltu = vs2 < vs1;

  always_comb begin
    case (aluop)
      vx_pkg::ALU_ADD: alu_res = vs2 + vs1;
      vx_pkg::ALU_AND: alu_res = vs2 & vs1;
      vx_pkg::ALU_OR:  alu_res = vs2 | vs1;
      vx_pkg::ALU_XOR: alu_res = vs2 ^ vs1;
      vx_pkg::ALU_MM: begin
        case (minmax)
          vx_pkg::MM_MIN:  alu_res = slt  ? vs2 : vs1;
          vx_pkg::MM_MINU: alu_res = sltu ? vs2 : vs1;
          vx_pkg::MM_MAX:  alu_res = slt  ? vs1 : vs2;
          default:         alu_res = sltu ? vs1 : vs2;
        endcase
      end
      default: alu_res = '0;
    endcase
  end

  // isolate lowest set bit, zero word gives zero here
  assign low_bit = vs2 & (~vs2 + 1'b1);

  // low_bit - 1 wraps to all ones for an empty word
  always_comb begin
    case (mask_op)
      vx_pkg::MASK_SBF: mask_res = low_bit - 1'b1;
      vx_pkg::MASK_SIF: mask_res = (low_bit - 1'b1) | low_bit;
      vx_pkg::MASK_SOF: mask_res = low_bit;
      default:          mask_res = vs2;
    endcase
  end

  assign result = (fu == vx_pkg::FU_MASK) ? mask_res : alu_res;

endmodule

//--- hdl/vx_ls_addr_gen.sv
// load/store element address generator for two lanes, with the running address buffer
`timescale 1ns/10ps
`include "vx_macros.svh"

module vx_ls_addr_gen (
  input  logic                   CLK,
  input  logic                   nRST,
  input  logic                   stall,
  input  logic                   flush,
  input  vx_pkg::dec_ex_t        dec,
  output logic [`VX_WORD_W-1:0]  addr0,
  output logic [`VX_WORD_W-1:0]  addr1
);

  logic [`VX_WORD_W-1:0]  eew_bytes;
  logic [`VX_WORD_W-1:0]  seg_base;
  logic [`VX_WORD_W-1:0]  stride;
  logic [`VX_WORD_W-1:0]  idx0;
  logic [`VX_WORD_W-1:0]  idx1;
  logic [`VX_WORD_W-1:0]  lin0;
  logic [`VX_WORD_W-1:0]  addr_buf;
  logic                   prev_ls;
  logic                   first_beat;

  always_comb begin
    case (dec.eew)
      vx_pkg::SEW8:  eew_bytes = `VX_WORD_W'd1;
      vx_pkg::SEW16: eew_bytes = `VX_WORD_W'd2;
      default:       eew_bytes = `VX_WORD_W'd4;
    endcase
  end

  // segment base skips nf fields
  assign seg_base = dec.xs1 + `VX_WORD_W'(dec.nf) * eew_bytes;

  always_comb begin
    case (dec.stride)
      vx_pkg::STRIDE_STRIDED: stride = dec.stride_val;
      vx_pkg::STRIDE_SEGMENT: stride = (`VX_WORD_W'(dec.nf) + 1'b1) * eew_bytes;
      default:                stride = `VX_WORD_W'(`VX_UNIT_STRIDE);
    endcase
  end

  // index scaled by SEW bytes
  always_comb begin
    case (dec.sew)
      vx_pkg::SEW8: begin
        idx0 = dec.vs2_lane0;
        idx1 = dec.vs2_lane1;
      end
      vx_pkg::SEW16: begin
        idx0 = dec.vs2_lane0 << 1;
        idx1 = dec.vs2_lane1 << 1;
      end
      default: begin
        idx0 = dec.vs2_lane0 << 2;
        idx1 = dec.vs2_lane1 << 2;
      end
    endcase
  end

  assign first_beat = (dec.woffset0 == '0) & ~prev_ls;
  assign lin0       = first_beat ? seg_base : addr_buf + stride;
  assign addr0      = dec.ls_idx ? seg_base + idx0 : lin0;
  assign addr1      = dec.ls_idx ? seg_base + idx1 : lin0 + stride;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      addr_buf <= '0;
      prev_ls  <= 1'b0;
    end else if (flush) begin
      addr_buf <= '0;
      prev_ls  <= 1'b0;
    end else if (!stall) begin
      addr_buf <= addr1;
      prev_ls  <= dec.valid & (dec.load | dec.store);
    end
  end

endmodule

//--- hdl/vx_mask_first.sv
// carries the first-set-bit state of sbf/sif/sof across lanes and beats
`timescale 1ns/10ps
`include "vx_macros.svh"

module vx_mask_first (
  input  logic                   CLK,
  input  logic                   nRST,
  input  logic                   stall,
  input  logic                   flush,
  input  vx_pkg::fu_e            fu,
  input  vx_pkg::mask_op_e       mask_op,
  input  logic [`VX_WORD_W-1:0]  lane0_raw,
  input  logic [`VX_WORD_W-1:0]  lane1_raw,
  input  logic [`VX_WORD_W-1:0]  res0,
  input  logic [`VX_WORD_W-1:0]  res1,
  output logic [`VX_WORD_W-1:0]  mask0,
  output logic [`VX_WORD_W-1:0]  mask1,
  output logic                   mask_override
);

  logic found;
  logic mask_active;
  logic lane0_hit;

  assign mask_active   = (fu == vx_pkg::FU_MASK) & (mask_op != vx_pkg::MASK_NONE);
  assign mask_override = mask_active;
  assign lane0_hit     = lane0_raw != '0;

  // lane 0 holds the lower 32 bits of the mask string
  assign mask0 = found ? '0 : res0;
  assign mask1 = (found | lane0_hit) ? '0 : res1;

  // held while stalled so the waiting beat sees the same state
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      found <= 1'b0;
    end else if (flush) begin
      found <= 1'b0;
    end else if (!stall) begin
      if (fu != vx_pkg::FU_MASK) begin
        found <= 1'b0;
      end else if (mask_active & (lane0_hit | (lane1_raw != '0))) begin
        found <= 1'b1;
      end
    end
  end

endmodule

//--- hdl/vx_result_latch.sv
// reduction combine, result mux and the execute-to-memory pipeline register
`timescale 1ns/10ps
`include "vx_macros.svh"

module vx_result_latch (
  input  logic                   CLK,
  input  logic                   nRST,
  input  logic                   stall,
  input  logic                   flush,
  input  vx_pkg::dec_ex_t        dec,
  input  logic [`VX_WORD_W-1:0]  res0,
  input  logic [`VX_WORD_W-1:0]  res1,
  input  logic [`VX_WORD_W-1:0]  mask0,
  input  logic [`VX_WORD_W-1:0]  mask1,
  input  logic                   mask_override,
  input  logic [`VX_WORD_W-1:0]  addr0,
  input  logic [`VX_WORD_W-1:0]  addr1,
  output vx_pkg::ex_mem_t        ex_mem
);

  logic [`VX_WORD_W-1:0]  red_res;
  logic                   ls;
  vx_pkg::ex_mem_t        nxt;

  // lane 1 result against lane 0 result, same op rules as the lanes
  vx_lane_alu i_reduce_alu (
    .vs1     (res0),
    .vs2     (res1),
    .aluop   (dec.aluop),
    .minmax  (dec.minmax),
    .mask_op (vx_pkg::MASK_NONE),
    .fu      (vx_pkg::FU_ALU),
    .sew     (dec.sew),
    .result  (red_res)
  );

  assign ls = dec.load | dec.store;

  always_comb begin
    nxt = '0;

    // only a valid beat may write or access memory
    nxt.load       = dec.valid & dec.load;
    nxt.store      = dec.valid & dec.store;
    nxt.wen        = dec.valid ? dec.wen : '0;
    nxt.ls_idx     = dec.ls_idx;
    nxt.woffset0   = dec.woffset0;
    nxt.woffset1   = dec.woffset1;
    nxt.vd         = dec.vd;
    nxt.eew        = dec.eew;
    nxt.storedata0 = dec.storedata0;
    nxt.storedata1 = dec.storedata1;

    if (ls) begin
      nxt.result0 = addr0;
    end else if (mask_override) begin
      nxt.result0 = mask0;
    end else if (dec.reduction_ena) begin
      nxt.result0 = red_res;
    end else if (dec.fu == vx_pkg::FU_MOVE_SCALAR) begin
      nxt.result0 = dec.vs1_lane0;
    end else if (dec.fu == vx_pkg::FU_MOVE) begin
      nxt.result0 = dec.vs2_lane0;
    end else begin
      nxt.result0 = res0;
    end

    // reduction leaves the raw lane 1 value in slot 1
    if (ls) begin
      nxt.result1 = addr1;
    end else if (mask_override) begin
      nxt.result1 = mask1;
    end else if (dec.reduction_ena) begin
      nxt.result1 = res1;
    end else if (dec.fu == vx_pkg::FU_MOVE_SCALAR) begin
      nxt.result1 = dec.vs1_lane1;
    end else if (dec.fu == vx_pkg::FU_MOVE) begin
      nxt.result1 = dec.vs2_lane1;
    end else begin
      nxt.result1 = res1;
    end
  end

  // flush beats stall
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      ex_mem <= '0;
    end else if (flush) begin
      ex_mem <= '0;
    end else if (!stall) begin
      ex_mem <= nxt;
    end
  end

endmodule

//--- hdl/vx_execute_stage.sv
// top of the two-lane vector execute stage; decode bundle in, memory bundle out
`timescale 1ns/10ps
`include "vx_macros.svh"

module vx_execute_stage (
  input  logic             CLK,
  input  logic             nRST,
  input  logic             stall,
  input  logic             flush,
  input  vx_pkg::dec_ex_t  dec,
  output vx_pkg::ex_mem_t  ex_mem
);

  logic [`VX_WORD_W-1:0]  vs1_0;
  logic [`VX_WORD_W-1:0]  vs1_1;
  logic [`VX_WORD_W-1:0]  vs2_0;
  logic [`VX_WORD_W-1:0]  vs2_1;
  logic [`VX_WORD_W-1:0]  res0;
  logic [`VX_WORD_W-1:0]  res1;
  logic [`VX_WORD_W-1:0]  addr0;
  logic [`VX_WORD_W-1:0]  addr1;
  logic [`VX_WORD_W-1:0]  mask0;
  logic [`VX_WORD_W-1:0]  mask1;
  logic                   mask_override;

  vx_operand_select i_operand_select (
    .dec   (dec),
    .vs1_0 (vs1_0),
    .vs1_1 (vs1_1),
    .vs2_0 (vs2_0),
    .vs2_1 (vs2_1)
  );

  vx_lane_alu i_lane0 (
    .vs1     (vs1_0),
    .vs2     (vs2_0),
    .aluop   (dec.aluop),
    .minmax  (dec.minmax),
    .mask_op (dec.mask_op),
    .fu      (dec.fu),
    .sew     (dec.sew),
    .result  (res0)
  );

  vx_lane_alu i_lane1 (
    .vs1     (vs1_1),
    .vs2     (vs2_1),
    .aluop   (dec.aluop),
    .minmax  (dec.minmax),
    .mask_op (dec.mask_op),
    .fu      (dec.fu),
    .sew     (dec.sew),
    .result  (res1)
  );

  vx_ls_addr_gen i_ls_addr_gen (
    .CLK   (CLK),
    .nRST  (nRST),
    .stall (stall),
    .flush (flush),
    .dec   (dec),
    .addr0 (addr0),
    .addr1 (addr1)
  );

  // raw vs2 words tell the mask unit where the first set bit lies
  vx_mask_first i_mask_first (
    .CLK           (CLK),
    .nRST          (nRST),
    .stall         (stall),
    .flush         (flush),
    .fu            (dec.fu),
    .mask_op       (dec.mask_op),
    .lane0_raw     (vs2_0),
    .lane1_raw     (vs2_1),
    .res0          (res0),
    .res1          (res1),
    .mask0         (mask0),
    .mask1         (mask1),
    .mask_override (mask_override)
  );

  vx_result_latch i_result_latch (
    .CLK           (CLK),
    .nRST          (nRST),
    .stall         (stall),
    .flush         (flush),
    .dec           (dec),
    .res0          (res0),
    .res1          (res1),
    .mask0         (mask0),
    .mask1         (mask1),
    .mask_override (mask_override),
    .addr0         (addr0),
    .addr1         (addr1),
    .ex_mem        (ex_mem)
  );

endmodule

//--- test/vx_execute_assert.sv
// concurrent checks on the execute-to-memory outputs that the testbench binds into vx_execute_stage
`timescale 1ns/10ps

module vx_execute_assert (
  input logic             CLK,
  input logic             nRST,
  input logic             stall,
  input logic             flush,
  input vx_pkg::ex_mem_t  ex_mem
);

  int fail_count = 0;

  // no memory access or write while in reset
  reset_idle: assert property (@(posedge CLK)
    !nRST |-> (!ex_mem.load && !ex_mem.store && ex_mem.wen == '0))
    else begin
      $error("memory request or write enable active during reset");
      fail_count++;
    end

  flush_clears: assert property (@(posedge CLK) disable iff (!nRST)
    flush |=> (ex_mem == '0))
    else begin
      $error("ex_mem not cleared one cycle after flush");
      fail_count++;
    end

  // flush takes priority so only a plain stall must hold
  stall_holds: assert property (@(posedge CLK) disable iff (!nRST)
    (stall && !flush) |=> $stable(ex_mem))
    else begin
      $error("ex_mem changed while stalled");
      fail_count++;
    end

endmodule

//--- test/tb_vx_execute.sv
// self-checking testbench for vx_execute_stage that compares LFSR-driven beats against a cycle model
`timescale 1ns/10ps
`include "vx_macros.svh"

module tb_vx_execute;

  localparam int N_ALU      = 60;
  localparam int N_RED      = 30;
  localparam int N_LS       = 6;
  localparam int N_IDX      = 10;
  localparam int N_MASK_SEQ = 5;
  localparam int N_MASK_LEN = 4;
  localparam int N_MIX      = 40;
  localparam int N_MOVE     = 16;
  // one idle beat closes each load/store and mask run, and reset adds three cycles
  localparam int N_BEATS = N_ALU + N_RED + 3 * (N_LS + 1) + N_IDX + 1
                         + N_MASK_SEQ * (N_MASK_LEN + 1) + N_MIX + N_MOVE + 3;
  localparam int MAX_CYCLES = N_BEATS * 3 / 2;

  logic                   CLK;
  logic                   nRST;
  logic                   stall;
  logic                   flush;
  vx_pkg::dec_ex_t        dec;
  vx_pkg::ex_mem_t        ex_mem;

  // model state mirroring the latch, address buffer and found flag
  vx_pkg::ex_mem_t        exp_q;
  logic [`VX_WORD_W-1:0]  m_buf;
  logic                   m_prev_ls;
  logic                   m_found;
  logic [31:0]            lfsr;
  int                     cycles;

  vx_execute_stage i_vx_execute_stage (
    .CLK    (CLK),
    .nRST   (nRST),
    .stall  (stall),
    .flush  (flush),
    .dec    (dec),
    .ex_mem (ex_mem)
  );

  bind vx_execute_stage vx_execute_assert i_vx_execute_assert (
    .CLK    (CLK),
    .nRST   (nRST),
    .stall  (stall),
    .flush  (flush),
    .ex_mem (ex_mem)
  );

  initial CLK = 1'b0;
  always #20 CLK = ~CLK;

  always @(posedge CLK) begin
    cycles = cycles + 1;
    if (i_vx_execute_stage.i_vx_execute_assert.fail_count != 0) begin
      abort_run("concurrent assertion in vx_execute_assert failed");
    end
    if (cycles > MAX_CYCLES) begin
      abort_run($sformatf("timeout, tests still running after %0d cycles", cycles));
    end
  end

  task abort_run(input string why);
    $display("%s", why);
    $display(">>> FAIL");
    $fatal(1, "stopping at first error");
  endtask

  task compare_value(input string what, input logic [255:0] got, input logic [255:0] want);
    if (got !== want) begin
      abort_run($sformatf("FAIL at %0d ns: %s, got %0h expected %0h", $time, what, got, want));
    end
  endtask

  // taps of x^32 + x^22 + x^2 + x + 1 stepped once per bit
  function automatic logic [31:0] lfsr_bits(input int n);
    logic [31:0] r;
    logic        fb;
    int          i;
    r = '0;
    for (i = 0; i < n; i++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      r    = {r[30:0], fb};
    end
    return r;
  endfunction

  function automatic logic [1:0] three_way();
    logic [1:0] v;
    v = 2'(lfsr_bits(2));
    return (v == 2'd3) ? 2'd0 : v;
  endfunction

  // mostly empty words so the first set bit lands in later lanes and beats
  function automatic logic [31:0] sparse_word();
    logic        hit;
    logic [31:0] w;
    logic [4:0]  sh;
    hit = lfsr_bits(2) == '0;
    w   = lfsr_bits(32);
    sh  = 5'(lfsr_bits(5));
    return hit ? (w << sh) : '0;
  endfunction

  function automatic logic [31:0] size_bytes(input vx_pkg::sew_e s);
    case (s)
      vx_pkg::SEW8:  return 32'd1;
      vx_pkg::SEW16: return 32'd2;
      default:       return 32'd4;
    endcase
  endfunction

  function automatic logic [31:0] sign_ext(input logic [31:0] x, input vx_pkg::sew_e s);
    case (s)
      vx_pkg::SEW8:  return {{24{x[7]}}, x[7:0]};
      vx_pkg::SEW16: return {{16{x[15]}}, x[15:0]};
      default:       return x;
    endcase
  endfunction

  function automatic logic [31:0] operand(input vx_pkg::src_e src, input logic [31:0] lane,
                                          input logic [31:0] imm, input logic [31:0] x);
    case (src)
      vx_pkg::SRC_V: return lane;
      vx_pkg::SRC_I: return imm;
      vx_pkg::SRC_X: return x;
      default:       return '0;
    endcase
  endfunction

  // a is vs2 and b is vs1
  function automatic logic [31:0] elem_op(input logic [31:0] a, input logic [31:0] b,
                                          input vx_pkg::aluop_e op, input vx_pkg::minmax_e mm,
                                          input vx_pkg::sew_e s);
    logic lt_s;
    logic lt_u;
    lt_s = $signed(sign_ext(a, s)) < $signed(sign_ext(b, s));
    lt_u = a < b;
    case (op)
      vx_pkg::ALU_ADD: return a + b;
      vx_pkg::ALU_AND: return a & b;
      vx_pkg::ALU_OR:  return a | b;
      vx_pkg::ALU_XOR: return a ^ b;
      vx_pkg::ALU_MM: begin
        case (mm)
          vx_pkg::MM_MIN:  return lt_s ? a : b;
          vx_pkg::MM_MINU: return lt_u ? a : b;
          vx_pkg::MM_MAX:  return lt_s ? b : a;
          default:         return lt_u ? b : a;
        endcase
      end
      default: return '0;
    endcase
  endfunction

  // sbf/sif/sof over the whole 64-bit mask string with bit 0 first
  function automatic logic [63:0] first_op(input logic [63:0] bits, input vx_pkg::mask_op_e op);
    logic [63:0] r;
    int          first;
    int          i;
    first = -1;
    for (i = 0; i < 64; i++) begin
      if (bits[i] && first < 0) first = i;
    end
    for (i = 0; i < 64; i++) begin
      case (op)
        vx_pkg::MASK_SBF: r[i] = (first < 0) || (i < first);
        vx_pkg::MASK_SIF: r[i] = (first < 0) || (i <= first);
        default:          r[i] = (i == first);
      endcase
    end
    return r;
  endfunction

  task automatic fresh_beat(output vx_pkg::dec_ex_t d);
    d            = '0;
    d.valid      = 1'b1;
    d.fu         = vx_pkg::FU_ALU;
    d.mask_op    = vx_pkg::MASK_NONE;
    d.sew        = vx_pkg::sew_e'(three_way());
    d.eew        = vx_pkg::sew_e'(three_way());
    d.stride     = vx_pkg::stride_e'(three_way());
    d.nf         = `VX_NF_W'(lfsr_bits(`VX_NF_W));
    d.vd         = `VX_REG_W'(lfsr_bits(`VX_REG_W));
    d.woffset0   = `VX_OFFSET_W'(lfsr_bits(`VX_OFFSET_W));
    d.woffset1   = `VX_OFFSET_W'(lfsr_bits(`VX_OFFSET_W));
    d.wen        = `VX_NLANES'(lfsr_bits(`VX_NLANES));
    d.vs1_lane0  = lfsr_bits(32);
    d.vs1_lane1  = lfsr_bits(32);
    d.vs2_lane0  = lfsr_bits(32);
    d.vs2_lane1  = lfsr_bits(32);
    d.storedata0 = lfsr_bits(32);
    d.storedata1 = lfsr_bits(32);
    d.imm        = lfsr_bits(32);
    d.xs1        = lfsr_bits(32);
    d.xs2        = lfsr_bits(32);
    d.stride_val = lfsr_bits(32);
  endtask

  task automatic pick_alu_op(inout vx_pkg::dec_ex_t d);
    d.aluop   = vx_pkg::aluop_e'(3'(lfsr_bits(3) % 5));
    d.minmax  = vx_pkg::minmax_e'(2'(lfsr_bits(2)));
    d.rs1_src = vx_pkg::src_e'(2'(lfsr_bits(2)));
    d.rs2_src = vx_pkg::src_e'(2'(lfsr_bits(2)));
    d.valid   = lfsr_bits(3) != '0;
  endtask

  // present one beat, predict its latch contents, check after the edge
  task automatic drive_beat(input vx_pkg::dec_ex_t d, input logic st, input logic fl);
    logic [31:0]     v1 [0:1];
    logic [31:0]     v2 [0:1];
    logic [31:0]     r [0:1];
    logic [31:0]     a [0:1];
    logic [63:0]     m;
    logic [31:0]     base;
    logic [31:0]     step;
    vx_pkg::ex_mem_t e;
    dec   = d;
    stall = st;
    flush = fl;
    v1[0] = operand(d.rs1_src, d.vs1_lane0, d.imm, d.xs1);
    v1[1] = operand(d.rs1_src, d.vs1_lane1, d.imm, d.xs1);
    v2[0] = operand(d.rs2_src, d.vs2_lane0, d.imm, d.xs2);
    v2[1] = operand(d.rs2_src, d.vs2_lane1, d.imm, d.xs2);
    r[0]  = elem_op(v2[0], v1[0], d.aluop, d.minmax, d.sew);
    r[1]  = elem_op(v2[1], v1[1], d.aluop, d.minmax, d.sew);
    m     = m_found ? '0 : first_op({v2[1], v2[0]}, d.mask_op);
    base  = d.xs1 + 32'(d.nf) * size_bytes(d.eew);
    case (d.stride)
      vx_pkg::STRIDE_STRIDED: step = d.stride_val;
      vx_pkg::STRIDE_SEGMENT: step = (32'(d.nf) + 1) * size_bytes(d.eew);
      default:                step = `VX_UNIT_STRIDE;
    endcase
    if (d.ls_idx) begin
      a[0] = base + d.vs2_lane0 * size_bytes(d.sew);
      a[1] = base + d.vs2_lane1 * size_bytes(d.sew);
    end else begin
      a[0] = (d.woffset0 == '0 && !m_prev_ls) ? base : m_buf + step;
      a[1] = a[0] + step;
    end
    e            = '0;
    e.load       = d.valid & d.load;
    e.store      = d.valid & d.store;
    e.wen        = d.valid ? d.wen : '0;
    e.ls_idx     = d.ls_idx;
    e.woffset0   = d.woffset0;
    e.woffset1   = d.woffset1;
    e.vd         = d.vd;
    e.eew        = d.eew;
    e.storedata0 = d.storedata0;
    e.storedata1 = d.storedata1;
    if (d.load || d.store) begin
      e.result0 = a[0];
      e.result1 = a[1];
    end else if (d.fu == vx_pkg::FU_MASK && d.mask_op != vx_pkg::MASK_NONE) begin
      e.result0 = m[31:0];
      e.result1 = m[63:32];
    end else if (d.reduction_ena) begin
      e.result0 = elem_op(r[1], r[0], d.aluop, d.minmax, d.sew);
      e.result1 = r[1];
    end else if (d.fu == vx_pkg::FU_MOVE_SCALAR) begin
      e.result0 = d.vs1_lane0;
      e.result1 = d.vs1_lane1;
    end else if (d.fu == vx_pkg::FU_MOVE) begin
      e.result0 = d.vs2_lane0;
      e.result1 = d.vs2_lane1;
    end else begin
      e.result0 = r[0];
      e.result1 = r[1];
    end
    @(posedge CLK);
    #2;
    if (fl) begin
      exp_q     = '0;
      m_buf     = '0;
      m_prev_ls = 1'b0;
      m_found   = 1'b0;
    end else if (!st) begin
      exp_q     = e;
      m_buf     = a[1];
      m_prev_ls = d.valid & (d.load | d.store);
      if (d.fu != vx_pkg::FU_MASK) begin
        m_found = 1'b0;
      end else if (d.mask_op != vx_pkg::MASK_NONE && (v2[0] | v2[1]) != '0) begin
        m_found = 1'b1;
      end
    end
    compare_value("result0", ex_mem.result0, exp_q.result0);
    compare_value("result1", ex_mem.result1, exp_q.result1);
    compare_value("ex_mem bundle", ex_mem, exp_q);
  endtask

  // one load/store run with fixed base and stride and a closing idle beat
  task automatic ls_sequence(input vx_pkg::stride_e mode, input logic idx, input int n);
    vx_pkg::dec_ex_t base_d;
    vx_pkg::dec_ex_t d;
    int              k;
    fresh_beat(base_d);
    base_d.fu     = vx_pkg::FU_LS;
    base_d.stride = mode;
    base_d.ls_idx = idx;
    for (k = 0; k < n; k++) begin
      d            = base_d;
      d.load       = 1'(lfsr_bits(1));
      d.store      = !d.load;
      d.vs2_lane0  = lfsr_bits(8);
      d.vs2_lane1  = lfsr_bits(8);
      d.storedata0 = lfsr_bits(32);
      d.storedata1 = lfsr_bits(32);
      d.woffset0   = `VX_OFFSET_W'(2 * k);
      d.woffset1   = `VX_OFFSET_W'(2 * k + 1);
      drive_beat(d, 1'b0, 1'b0);
    end
    fresh_beat(d);
    d.valid = 1'b0;
    drive_beat(d, 1'b0, 1'b0);
  endtask

  // several beats of one mask op followed by an alu beat that ends the instruction
  task automatic mask_sequence(input int n);
    vx_pkg::dec_ex_t  d;
    vx_pkg::mask_op_e op;
    int               k;
    op = vx_pkg::mask_op_e'(three_way());
    for (k = 0; k < n; k++) begin
      fresh_beat(d);
      d.fu        = vx_pkg::FU_MASK;
      d.mask_op   = op;
      d.vs2_lane0 = sparse_word();
      d.vs2_lane1 = sparse_word();
      drive_beat(d, 1'b0, 1'b0);
    end
    fresh_beat(d);
    drive_beat(d, 1'b0, 1'b0);
  endtask

  initial begin
    vx_pkg::dec_ex_t d;
    logic            st;
    logic            fl;
    int              k;
    lfsr      = 32'h47e8_30df;
    cycles    = 0;
    nRST      = 1'b1;
    stall     = 1'b0;
    flush     = 1'b0;
    dec       = '0;
    exp_q     = '0;
    m_buf     = '0;
    m_prev_ls = 1'b0;
    m_found   = 1'b0;
    #5;
    nRST = 1'b0;
    repeat (2) @(posedge CLK);
    #2;
    nRST = 1'b1;
    compare_value("ex_mem after reset", ex_mem, '0);

    for (k = 0; k < N_ALU; k++) begin
      fresh_beat(d);
      pick_alu_op(d);
      drive_beat(d, 1'b0, 1'b0);
    end
    for (k = 0; k < N_RED; k++) begin
      fresh_beat(d);
      pick_alu_op(d);
      d.reduction_ena = 1'b1;
      drive_beat(d, 1'b0, 1'b0);
    end

    // linear runs in every stride mode and then indexed
    ls_sequence(vx_pkg::STRIDE_UNIT, 1'b0, N_LS);
    ls_sequence(vx_pkg::STRIDE_STRIDED, 1'b0, N_LS);
    ls_sequence(vx_pkg::STRIDE_SEGMENT, 1'b0, N_LS);
    ls_sequence(vx_pkg::STRIDE_UNIT, 1'b1, N_IDX);

    for (k = 0; k < N_MASK_SEQ; k++) begin
      mask_sequence(N_MASK_LEN);
    end

    // random stall and flush over mixed alu and mask beats
    for (k = 0; k < N_MIX; k++) begin
      fresh_beat(d);
      if (lfsr_bits(1)) begin
        d.fu        = vx_pkg::FU_MASK;
        d.mask_op   = vx_pkg::mask_op_e'(three_way());
        d.vs2_lane0 = sparse_word();
        d.vs2_lane1 = sparse_word();
      end else begin
        pick_alu_op(d);
      end
      st = lfsr_bits(2) == '0;
      fl = lfsr_bits(3) == '0;
      drive_beat(d, st, fl);
    end

    for (k = 0; k < N_MOVE; k++) begin
      fresh_beat(d);
      d.fu      = lfsr_bits(1) ? vx_pkg::FU_MOVE : vx_pkg::FU_MOVE_SCALAR;
      d.rs1_src = vx_pkg::src_e'(2'(lfsr_bits(2)));
      drive_beat(d, 1'b0, 1'b0);
    end

    if (i_vx_execute_stage.i_vx_execute_assert.fail_count != 0) begin
      abort_run("concurrent assertion in vx_execute_assert failed");
    end else begin
      $display(">>> PASS");
      $finish;
    end
  end

endmodule

//--- vx_execute.f
+incdir+hdl
hdl/vx_pkg.sv
hdl/vx_operand_select.sv
hdl/vx_lane_alu.sv
hdl/vx_ls_addr_gen.sv
hdl/vx_mask_first.sv
hdl/vx_result_latch.sv
hdl/vx_execute_stage.sv
test/vx_execute_assert.sv
test/tb_vx_execute.sv

//--- Bender.yml
package:
  name: vx_execute

export_include_dirs:
  - hdl

sources:
  - hdl/vx_pkg.sv
  - hdl/vx_operand_select.sv
  - hdl/vx_lane_alu.sv
  - hdl/vx_ls_addr_gen.sv
  - hdl/vx_mask_first.sv
  - hdl/vx_result_latch.sv
  - hdl/vx_execute_stage.sv
  - target: simulation
    files:
      - test/vx_execute_assert.sv
      - test/tb_vx_execute.sv
